/* verilog/loadUnitPkg.sv */
/*
 * Load unit package
 * Shared widths, load opcodes, access size codes, the sequencer
 * state encoding and the acknowledge time limit
 */

package loadUnitPkg;

	// ========================================================================
	// Word widths
	// ========================================================================

	// A micro-op carries its opcode in bits 6:0 and Rs1 in bits 12:8
	typedef logic [31:0] microOp_t;
	typedef logic [6:0]  opcode_t;
	typedef logic [4:0]  regSel_t;

	// Byte address into memory and the full data word read back
	typedef logic [31:0] addr_t;
	typedef logic [63:0] word_t;

	// Access size code, which also selects the lane width
	typedef logic [1:0]  accessSize_t;

	localparam accessSize_t SIZE_BYTE  = 2'd0;
	localparam accessSize_t SIZE_WYDE  = 2'd1;
	localparam accessSize_t SIZE_TETRA = 2'd2;
	localparam accessSize_t SIZE_OCTA  = 2'd3;

	// ========================================================================
	// Load opcodes
	// ========================================================================

	// Sign-extending loads
	localparam opcode_t OP_LDB  = 7'd16;
	localparam opcode_t OP_LDW  = 7'd17;
	localparam opcode_t OP_LDT  = 7'd18;
	localparam opcode_t OP_LDO  = 7'd19;

	// Zero-extending loads
	localparam opcode_t OP_LDBZ = 7'd20;
	localparam opcode_t OP_LDWZ = 7'd21;
	localparam opcode_t OP_LDTZ = 7'd22;

	// Tetra load whose extension is picked by bit 2 of Rs1
	localparam opcode_t OP_LDIP = 7'd23;

	// Wait cycles allowed after the request before giving up
	typedef logic [4:0] waitCount_t;
	localparam waitCount_t ACK_LIMIT = 5'd16;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_REQUEST,
		SEQ_WAIT,
		SEQ_DONE
	} seqState_t;

endpackage

/* verilog/decodeIf.sv */
/*
 * Decoded load attributes
 * Carries the decoder's verdict to the sequencer and the aligner
 */

`timescale 1ns/10ps

interface decodeIf;
	import loadUnitPkg::*;

	// Load classification, isLoad and notLoad are always complements
	logic        isLoad;
	logic        notLoad;
	// Extension and access size for the aligner
	logic        zeroExt;
	accessSize_t size;

	modport decoder (
		output isLoad, notLoad, zeroExt, size
	);

	// Sequencer uses the classification, aligner the size and extension
	modport consumer (
		input isLoad, notLoad, zeroExt, size
	);

endinterface

/* verilog/loadDecode.sv */
/*
 * Load decoder
 * Classifies a micro-op as a load and works out its access size
 * and whether the loaded value is zero-extended
 */

`timescale 1ns/10ps

module loadDecode (
	input loadUnitPkg::microOp_t instr,
	decodeIf.decoder dec
);
	import loadUnitPkg::*;

	opcode_t opcode;
	regSel_t rs1;

	// Field extraction
	assign opcode = instr[6:0];
	assign rs1 = instr[12:8];

	always_comb
	begin
		// Anything not listed below is not a load
		dec.isLoad = 1'b0;
		dec.zeroExt = 1'b0;
		dec.size = SIZE_OCTA;
		case (opcode)
		OP_LDB, OP_LDBZ:
			begin
				dec.isLoad = 1'b1;
				dec.size = SIZE_BYTE;
				dec.zeroExt = (opcode == OP_LDBZ);
			end
		OP_LDW, OP_LDWZ:
			begin
				dec.isLoad = 1'b1;
				dec.size = SIZE_WYDE;
				dec.zeroExt = (opcode == OP_LDWZ);
			end
		OP_LDT, OP_LDTZ:
			begin
				dec.isLoad = 1'b1;
				dec.size = SIZE_TETRA;
				dec.zeroExt = (opcode == OP_LDTZ);
			end
		OP_LDO:
			begin
				// Full word, extension makes no difference
				dec.isLoad = 1'b1;
				dec.size = SIZE_OCTA;
			end
		OP_LDIP:
			begin
				// Extension mode rides in Rs1 bit 2, set means zero-extend
				dec.isLoad = 1'b1;
				dec.size = SIZE_TETRA;
				dec.zeroExt = rs1[2];
			end
		default:
			dec.isLoad = 1'b0;
		endcase
	end

	assign dec.notLoad = ~dec.isLoad;

endmodule

/* verilog/ackTimer.sv */
/*
 * Acknowledge timer
 * Counts wait cycles since the memory request and flags a timeout
 * once the acknowledge limit is reached
 */

`timescale 1ns/10ps

module ackTimer (
	input  logic clk,
	input  logic reset,
	input  logic clear,
	input  logic count,
	output logic expired
);
	import loadUnitPkg::*;

	waitCount_t waitCount;
	logic reached;
	logic lastWait;

	// Counter has hit the limit and sits there
	assign reached = (waitCount == ACK_LIMIT);

	// The wait cycle in progress is the last one allowed
	assign lastWait = count && (waitCount == ACK_LIMIT - 1'b1);

	// Saturating count of completed wait cycles
	always_ff @(posedge clk)
	begin
		if (reset || clear)
			waitCount <= '0;
		else if (count && !reached)
			waitCount <= waitCount + 1'b1;
	end

	// Timeout shows in the limit cycle itself and stays up after it
	assign expired = reached || lastWait;

endmodule

/* verilog/loadSequencer.sv */
/*
 * Load sequencer
 * Accepts a start, issues one memory request for a load, waits for
 * the acknowledge or a timeout and finishes with a done pulse
 */

`timescale 1ns/10ps

module loadSequencer (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic memAck,
	input  logic expired,
	decodeIf.consumer dec,
	output logic memReq,
	output logic busy,
	output logic done,
	output logic timeout,
	output logic illegal,
	output logic capture,
	output logic timerClear,
	output logic timerCount,
	output logic clearResult
);
	import loadUnitPkg::*;

	seqState_t state;
	seqState_t nextState;
	logic      illegalFlag;
	logic      timeoutFlag;
	logic      goIllegal;
	logic      goTimeout;

	// ========================================================================
	// Transition conditions
	// ========================================================================

	// Non-load accepted from idle goes straight to done
	assign goIllegal = (state == SEQ_IDLE) && start && dec.notLoad;

	// Acknowledge wins over a timeout landing in the same cycle
	assign goTimeout = (state == SEQ_WAIT) && !memAck && expired;

	always_comb
	begin
		nextState = state;
		case (state)
		SEQ_IDLE:
			begin
				if (start && dec.isLoad)
					nextState = SEQ_REQUEST;
				else if (goIllegal)
					nextState = SEQ_DONE;
			end
		SEQ_REQUEST:
			nextState = SEQ_WAIT;
		SEQ_WAIT:
			begin
				if (memAck || expired)
					nextState = SEQ_DONE;
			end
		SEQ_DONE:
			nextState = SEQ_IDLE;
		default:
			nextState = SEQ_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= SEQ_IDLE;
		else
			state <= nextState;
	end

	// ========================================================================
	// Status flags
	// ========================================================================

	// Set on the way into done, dropped when done is left
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			illegalFlag <= 1'b0;
			timeoutFlag <= 1'b0;
		end
		else if (state == SEQ_DONE)
		begin
			illegalFlag <= 1'b0;
			timeoutFlag <= 1'b0;
		end
		else
		begin
			if (goIllegal)
				illegalFlag <= 1'b1;
			if (goTimeout)
				timeoutFlag <= 1'b1;
		end
	end

	// Request and timer control
	assign memReq = (state == SEQ_REQUEST);
	assign timerClear = (state == SEQ_REQUEST);
	assign timerCount = (state == SEQ_WAIT);

	// Memory word is taken in the acknowledge cycle
	assign capture = (state == SEQ_WAIT) && memAck;

	// A failed access leaves a zero result
	assign clearResult = goIllegal || goTimeout;

	// Completion outputs
	assign busy = (state != SEQ_IDLE);
	assign done = (state == SEQ_DONE);
	assign illegal = illegalFlag;
	assign timeout = timeoutFlag;

endmodule

/* verilog/loadAlign.sv */
/*
 * Load aligner
 * Holds the access address and attributes, then picks the addressed
 * lane out of the returned word and extends it to the result
 */

`timescale 1ns/10ps

module loadAlign (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic busy,
	input  loadUnitPkg::addr_t addr,
	input  loadUnitPkg::word_t memData,
	input  logic capture,
	input  logic clearResult,
	decodeIf.consumer dec,
	output loadUnitPkg::addr_t memAddr,
	output loadUnitPkg::word_t result
);
	import loadUnitPkg::*;

	addr_t       addrReg;
	accessSize_t sizeReg;
	logic        zeroExtReg;
	logic [5:0]  shiftAmt;
	word_t       lane;
	word_t       extended;

	// Access attributes are taken when the sequencer accepts the start
	always_ff @(posedge clk)
	begin
		if (start && !busy)
		begin
			addrReg <= addr;
			sizeReg <= dec.size;
			zeroExtReg <= dec.zeroExt;
		end
	end

	// Address stays put for the whole access
	assign memAddr = addrReg;

	// ========================================================================
	// Lane selection and extension
	// ========================================================================

	// Bit offset of the lane, address bits below the size are ignored
	always_comb
	begin
		case (sizeReg)
		SIZE_BYTE:
			shiftAmt = {addrReg[2:0], 3'b000};
		SIZE_WYDE:
			shiftAmt = {addrReg[2:1], 4'b0000};
		SIZE_TETRA:
			shiftAmt = {addrReg[2], 5'b00000};
		default:
			shiftAmt = 6'd0;
		endcase
	end

	// Bring the wanted lane down to bit 0
	assign lane = memData >> shiftAmt;

	always_comb
	begin
		case (sizeReg)
		SIZE_BYTE:
			extended = zeroExtReg ? {56'd0, lane[7:0]} : {{56{lane[7]}}, lane[7:0]};
		SIZE_WYDE:
			extended = zeroExtReg ? {48'd0, lane[15:0]} : {{48{lane[15]}}, lane[15:0]};
		SIZE_TETRA:
			extended = zeroExtReg ? {32'd0, lane[31:0]} : {{32{lane[31]}}, lane[31:0]};
		default:
			extended = lane;
		endcase
	end

	// Result is loaded in the acknowledge cycle and zeroed on a failed access
	always_ff @(posedge clk)
	begin
		if (reset || clearResult)
			result <= '0;
		else if (capture)
			result <= extended;
	end

endmodule

/* verilog/loadUnit.sv */
/*
 * Load unit
 * Memory stage load path that decodes a micro-op, reads one word
 * from memory and returns the aligned, extended value
 */

`timescale 1ns/10ps

module loadUnit (
	input  logic clk,
	input  logic reset,
	// Request from the issue side
	input  logic start,
	input  loadUnitPkg::microOp_t instr,
	input  loadUnitPkg::addr_t addr,
	output logic busy,
	// Memory read port
	input  logic memAck,
	input  loadUnitPkg::word_t memData,
	output logic memReq,
	output loadUnitPkg::addr_t memAddr,
	// Completion
	output logic done,
	output loadUnitPkg::word_t result,
	output logic timeout,
	output logic illegal
);

	logic capture;
	logic clearResult;
	logic timerClear;
	logic timerCount;
	logic expired;

	// Decoded attributes of the micro-op on the instr port
	decodeIf decode_i ();

	loadDecode loadDecode_i (
		.instr (instr),
		.dec   (decode_i.decoder)
	);

	// ========================================================================
	// Control
	// ========================================================================

	loadSequencer loadSequencer_i (
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.memAck      (memAck),
		.expired     (expired),
		.dec         (decode_i.consumer),
		.memReq      (memReq),
		.busy        (busy),
		.done        (done),
		.timeout     (timeout),
		.illegal     (illegal),
		.capture     (capture),
		.timerClear  (timerClear),
		.timerCount  (timerCount),
		.clearResult (clearResult)
	);

	// Watches for an acknowledge that never arrives
	ackTimer ackTimer_i (
		.clk     (clk),
		.reset   (reset),
		.clear   (timerClear),
		.count   (timerCount),
		.expired (expired)
	);

	// ========================================================================
	// Data path
	// ========================================================================

	loadAlign loadAlign_i (
		.clk         (clk),
		.reset       (reset),
		.start       (start),
		.busy        (busy),
		.addr        (addr),
		.memData     (memData),
		.capture     (capture),
		.clearResult (clearResult),
		.dec         (decode_i.consumer),
		.memAddr     (memAddr),
		.result      (result)
	);

endmodule

/* verif/loadUnitTb.sv */
/*
 * Load unit testbench
 * Random loads against a memory model with random latency, checked
 * against a reference model of the opcode, lane and extension rules
 */

`timescale 1ns/10ps

module loadUnitTb;
	import loadUnitPkg::*;

	// Transactions per random test and the overall cycle budget
	localparam int RUNS = 25;
	localparam int TRANSACTIONS = 4 * RUNS + 2;
	localparam longint CYCLE_LIMIT = 40 * TRANSACTIONS;

	// Expected kind of completion
	localparam int KIND_LOAD = 0;
	localparam int KIND_ILLEGAL = 1;
	localparam int KIND_TIMEOUT = 2;

	logic clk;
	logic reset;
	logic start;
	microOp_t instr;
	addr_t addr;
	logic busy;
	logic memAck;
	word_t memData;
	logic memReq;
	addr_t memAddr;
	logic done;
	word_t result;
	logic timeout;
	logic illegal;

	// Monitor snapshots taken at the falling edge
	longint cycle;
	longint startCycle;
	longint reqCycle;
	longint ackCycle;
	longint doneCycle;
	addr_t reqAddr;
	addr_t doneAddr;
	word_t ackData;
	word_t doneResult;
	logic doneTimeout;
	logic doneIllegal;
	int reqCount;
	int ackCount;
	int doneCount;

	// Scoreboard and stimulus state
	logic busyExpected;
	logic lateMode;
	int ackDelay;
	int errorCount;
	int testCount;
	int failedTests;

	loadUnit dut_i (
		.clk     (clk),
		.reset   (reset),
		.start   (start),
		.instr   (instr),
		.addr    (addr),
		.busy    (busy),
		.memAck  (memAck),
		.memData (memData),
		.memReq  (memReq),
		.memAddr (memAddr),
		.done    (done),
		.result  (result),
		.timeout (timeout),
		.illegal (illegal)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#2 clk = ~clk;
	end

	// Stops a run where some transaction never completes
	initial
	begin
		cycle = 0;
		while (cycle <= CYCLE_LIMIT)
		begin
			@(posedge clk);
			cycle <= cycle + 1;
		end
		$display("Run stopped after %0d cycles, a transaction never finished", cycle);
		$display("Testbench failed");
		$finish;
	end

	// ========================================================================
	// Memory model and monitor
	// ========================================================================

	// Answers each request after 1 to 6 cycles, or long after the timeout
	initial
	begin
		memAck = 1'b0;
		memData = '0;
		forever
		begin
			@(negedge clk);
			if (memReq)
			begin
				if (lateMode)
					ackDelay = ACK_LIMIT + 4;
				else
					ackDelay = $urandom_range(1, 6);
				repeat (ackDelay) @(posedge clk);
				memAck <= 1'b1;
				memData <= {$urandom, $urandom};
				@(posedge clk);
				memAck <= 1'b0;
			end
		end
	end

	initial
	begin
		reqCount = 0;
		ackCount = 0;
		doneCount = 0;
		busyExpected = 1'b0;
		forever
		begin
			@(negedge clk);
			if (!reset)
			begin
				// Busy runs from the cycle after an accepted start through done
				if (busy !== busyExpected)
					logMismatch("busy", 64'(busyExpected), 64'(busy));
				// Only a start while idle is accepted
				if (start && !busyExpected)
				begin
					startCycle = cycle;
					busyExpected = 1'b1;
				end
				if (memReq)
				begin
					reqCount++;
					reqCycle = cycle;
					reqAddr = memAddr;
				end
				if (memAck)
				begin
					ackCount++;
					ackCycle = cycle;
					ackData = memData;
				end
				if (done)
				begin
					doneCount++;
					doneCycle = cycle;
					doneAddr = memAddr;
					doneResult = result;
					doneTimeout = timeout;
					doneIllegal = illegal;
					busyExpected = 1'b0;
				end
			end
		end
	end

	// ========================================================================
	// Reference model and checking helpers
	// ========================================================================

	// Expected load value built byte by byte from the addressed lane
	function automatic word_t refLoad(input microOp_t op, input addr_t a, input word_t data);
		int nBytes;
		int first;
		int i;
		logic zext;
		word_t value;
		if (op[6:0] == OP_LDIP)
		begin
			nBytes = 4;
			zext = op[10];
		end
		else if (op[6:0] >= OP_LDBZ)
		begin
			nBytes = 1 << (op[6:0] - OP_LDBZ);
			zext = 1'b1;
		end
		else
		begin
			nBytes = 1 << (op[6:0] - OP_LDB);
			zext = 1'b0;
		end
		// Low address bits inside the lane are dropped
		first = (a[2:0] / nBytes) * nBytes;
		value = '0;
		for (i = 0; i < nBytes; i++)
			value[i * 8 +: 8] = data[(first + i) * 8 +: 8];
		if (!zext)
			for (i = nBytes; i < 8; i++)
				value[i * 8 +: 8] = {8{value[nBytes * 8 - 1]}};
		return value;
	endfunction

	task automatic logMismatch(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
		errorCount++;
	endtask

	task automatic complain(input string what);
		$display("Error at %0t: %s", $time, what);
		errorCount++;
	endtask

	task automatic issueOp(input microOp_t op, input addr_t a);
		@(posedge clk);
		start <= 1'b1;
		instr <= op;
		addr <= a;
		@(posedge clk);
		start <= 1'b0;
	endtask

	task automatic awaitDone(input int doneBefore);
		while (doneCount == doneBefore)
			@(posedge clk);
	endtask

	// Compares the completion snapshot with what the kind of access implies
	task automatic verifyDone(input microOp_t op, input addr_t a, input int kind,
		input int requests);
		word_t expected;
		expected = '0;
		if (kind == KIND_LOAD)
			expected = refLoad(op, a, ackData);
		if (doneResult !== expected)
			logMismatch("result", expected, doneResult);
		if (doneIllegal !== (kind == KIND_ILLEGAL))
			logMismatch("illegal", 64'(kind == KIND_ILLEGAL), 64'(doneIllegal));
		if (doneTimeout !== (kind == KIND_TIMEOUT))
			logMismatch("timeout", 64'(kind == KIND_TIMEOUT), 64'(doneTimeout));
		if (kind == KIND_ILLEGAL)
		begin
			if (requests != 0)
				complain($sformatf("non-load issued %0d memory requests", requests));
			if (doneCycle != startCycle + 1)
				logMismatch("done cycle", startCycle + 1, doneCycle);
		end
		else
		begin
			if (requests != 1)
				complain($sformatf("load issued %0d memory requests instead of one", requests));
			if (reqCycle != startCycle + 1)
				logMismatch("memReq cycle", startCycle + 1, reqCycle);
			if (reqAddr !== a)
				logMismatch("memAddr", 64'(a), 64'(reqAddr));
			if (doneAddr !== a)
				logMismatch("memAddr at done", 64'(a), 64'(doneAddr));
			if (kind == KIND_LOAD && doneCycle != ackCycle + 1)
				logMismatch("done cycle", ackCycle + 1, doneCycle);
			// The wait state starts the cycle after the request
			if (kind == KIND_TIMEOUT && doneCycle != reqCycle + 1 + ACK_LIMIT)
				logMismatch("done cycle", reqCycle + 1 + ACK_LIMIT, doneCycle);
		end
	endtask

	task automatic transact(input microOp_t op, input addr_t a, input int kind);
		int reqBefore;
		int doneBefore;
		reqBefore = reqCount;
		doneBefore = doneCount;
		issueOp(op, a);
		awaitDone(doneBefore);
		verifyDone(op, a, kind, reqCount - reqBefore);
	endtask

	task automatic finishTest(input string name, input int errBefore);
		testCount++;
		if (errorCount == errBefore)
			$display("Test %0d %s: ok", testCount, name);
		else
		begin
			failedTests++;
			$display("Test %0d %s: %0d errors", testCount, name, errorCount - errBefore);
		end
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial
	begin
		microOp_t op;
		microOp_t otherOp;
		addr_t a;
		logic [31:0] pick;
		int n;
		int errBefore;
		int reqBefore;
		int doneBefore;
		int ackBefore;

		void'($urandom(53));
		reset = 1'b1;
		start = 1'b0;
		instr = '0;
		addr = '0;
		lateMode = 1'b0;
		errorCount = 0;
		testCount = 0;
		failedTests = 0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// Outputs straight after reset
		errBefore = errorCount;
		@(negedge clk);
		if ({memReq, done, busy, timeout, illegal} !== 5'b0)
			logMismatch("control outputs", 64'd0, 64'({memReq, done, busy, timeout, illegal}));
		if (result !== '0)
			logMismatch("result", 64'd0, result);
		finishTest("reset values", errBefore);

		errBefore = errorCount;
		for (n = 0; n < RUNS; n++)
		begin
			pick = $urandom;
			op = $urandom;
			op[6:0] = OP_LDB + pick[1:0];
			a = $urandom;
			transact(op, a, KIND_LOAD);
		end
		finishTest("sign-extended loads", errBefore);

		errBefore = errorCount;
		for (n = 0; n < RUNS; n++)
		begin
			pick = $urandom_range(0, 2);
			op = $urandom;
			op[6:0] = OP_LDBZ + pick[6:0];
			a = $urandom;
			transact(op, a, KIND_LOAD);
		end
		finishTest("zero-extended loads", errBefore);

		// Random upper bits give a random Rs1 and so a random extension
		errBefore = errorCount;
		for (n = 0; n < RUNS; n++)
		begin
			op = $urandom;
			op[6:0] = OP_LDIP;
			a = $urandom;
			transact(op, a, KIND_LOAD);
		end
		finishTest("LDIP loads", errBefore);

		errBefore = errorCount;
		for (n = 0; n < RUNS; n++)
		begin
			pick = $urandom;
			while (pick[6:0] >= OP_LDB && pick[6:0] <= OP_LDIP)
				pick = $urandom;
			op = $urandom;
			op[6:0] = pick[6:0];
			a = $urandom;
			transact(op, a, KIND_ILLEGAL);
		end
		finishTest("non-load opcodes", errBefore);

		// Memory answers only well after the limit and that answer must be dropped
		errBefore = errorCount;
		lateMode = 1'b1;
		op = $urandom;
		op[6:0] = OP_LDT;
		a = $urandom;
		transact(op, a, KIND_TIMEOUT);
		doneBefore = doneCount;
		ackBefore = ackCount;
		while (ackCount == ackBefore)
			@(posedge clk);
		repeat (3) @(posedge clk);
		@(negedge clk);
		if (doneCount != doneBefore)
			complain("late acknowledge produced another done");
		if (result !== '0)
			logMismatch("result", 64'd0, result);
		lateMode = 1'b0;
		finishTest("acknowledge timeout", errBefore);

		// Second start lands while the first load is still in flight
		errBefore = errorCount;
		reqBefore = reqCount;
		doneBefore = doneCount;
		op = $urandom;
		op[6:0] = OP_LDO;
		a = $urandom;
		otherOp = $urandom;
		otherOp[6:0] = OP_LDBZ;
		issueOp(op, a);
		@(posedge clk);
		start <= 1'b1;
		instr <= otherOp;
		addr <= ~a;
		@(posedge clk);
		start <= 1'b0;
		awaitDone(doneBefore);
		repeat (6) @(posedge clk);
		verifyDone(op, a, KIND_LOAD, reqCount - reqBefore);
		if (doneCount - doneBefore != 1)
			complain("start during busy led to an extra done");
		finishTest("start while busy", errBefore);

		$display("%0d tests run, %0d failed, %0d errors", testCount, failedTests, errorCount);
		if (errorCount == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* tb.f */
verilog/loadUnitPkg.sv
verilog/decodeIf.sv
verilog/loadDecode.sv
verilog/ackTimer.sv
verilog/loadSequencer.sv
verilog/loadAlign.sv
verilog/loadUnit.sv
verif/loadUnitTb.sv

/* Makefile */
# Verilator simulation of the load unit

TOP := loadUnitTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
